// ==== hw/host_mem_settings.svh ====
`ifndef HOST_MEM_SETTINGS_SVH
`define HOST_MEM_SETTINGS_SVH

// Host memory is word addressed, so this is the number of word address bits
`define HOST_MEM_ADDR_W 8

// Width of one memory word and of the data buses
`define HOST_MEM_DATA_W 64
`define HOST_MEM_BE_W (`HOST_MEM_DATA_W / 8)

// Number of words held by the host memory endpoint
`define HOST_MEM_DEPTH (1 << `HOST_MEM_ADDR_W)

// Endpoint latencies in cycles, counted from the accepting edge
`define HOST_MEM_RD_LATENCY 3
`define HOST_MEM_WR_LATENCY 2

// The endpoint stalls one cycle in every period of this many cycles
`define HOST_MEM_WAIT_PERIOD 4

// Register stages between the converter and the endpoint
`define HOST_MEM_TIMING_STAGES 1

`endif

// ==== hw/host_mem_pkg.sv ====
`include "host_mem_settings.svh"

package host_mem_pkg;

    // Basic field types, sized from the shared settings
    typedef logic [`HOST_MEM_ADDR_W-1:0] addr_t;
    typedef logic [`HOST_MEM_DATA_W-1:0] data_t;
    typedef logic [`HOST_MEM_BE_W-1:0]   be_t;

    // Request on the read channel of the split bus
    // The read strobe travels beside it as its own signal
    typedef struct packed {
        addr_t address;
    } rd_req_t;

    // Request on the write channel of the split bus
    // Every byte with its enable bit set is written
    typedef struct packed {
        addr_t address;
        data_t writedata;
        be_t   byteenable;
    } wr_req_t;

    // Request on the merged Avalon memory port
    // At most one of read and write is set in any cycle
    // Writedata and byteenable only matter for a write
    typedef struct packed {
        logic  read;
        logic  write;
        addr_t address;
        data_t writedata;
        be_t   byteenable;
    } mem_req_t;

    // Response on the merged port
    // Both valid bits are single-cycle pulses with no back-pressure
    // A read response and a write response may arrive in the same cycle
    typedef struct packed {
        logic  readdatavalid;
        data_t readdata;
        logic  writeresponsevalid;
    } mem_rsp_t;

endpackage

// ==== hw/avalon_rdwr_to_mem.sv ====
module avalon_rdwr_to_mem (
    input  logic                  clk,
    input  logic                  rst,

    // Read channel from the accelerator
    input  logic                  rd_read,
    input  host_mem_pkg::rd_req_t rd_req,
    output logic                  rd_waitrequest,
    output logic                  rd_readdatavalid,
    output host_mem_pkg::data_t   rd_readdata,

    // Write channel from the accelerator
    input  logic                  wr_write,
    input  host_mem_pkg::wr_req_t wr_req,
    output logic                  wr_waitrequest,
    output logic                  wr_writeresponsevalid,

    // Merged Avalon port toward the memory side
    output host_mem_pkg::mem_req_t mem_req,
    input  logic                   mem_waitrequest,
    input  host_mem_pkg::mem_rsp_t mem_rsp
);

    // Set when the write channel wins the next tie between both channels
    logic prefer_wr;

    // A presented request that saw waitrequest stays selected until taken
    logic lock_q;
    logic lock_wr_q;

    // Channel selection for the current cycle
    logic pick_wr;
    logic grant_rd;
    logic grant_wr;
    logic accepted;

    // Pick a channel
    // A locked choice comes first, then the fairness bit on a tie
    always_comb begin
        if (lock_q) begin
            pick_wr = lock_wr_q;
        end else if (rd_read && wr_write) begin
            pick_wr = prefer_wr;
        end else begin
            pick_wr = wr_write;
        end
    end

    assign grant_wr = wr_write && pick_wr;
    assign grant_rd = rd_read && !pick_wr;

    // The merged request is taken when it is presented and not stalled
    assign accepted = (grant_rd || grant_wr) && !mem_waitrequest;

    // Build the merged request from the granted channel
    always_comb begin
        mem_req.read      = grant_rd;
        mem_req.write     = grant_wr;
        mem_req.address   = pick_wr ? wr_req.address : rd_req.address;
        mem_req.writedata = wr_req.writedata;
        // Reads fetch whole words, so all bytes are enabled
        mem_req.byteenable = pick_wr ? wr_req.byteenable : '1;
    end

    // The losing channel always sees a stall
    // The winner sees the stall of the merged port
    assign rd_waitrequest = !grant_rd || mem_waitrequest;
    assign wr_waitrequest = !grant_wr || mem_waitrequest;

    // Fairness and lock state
    always_ff @(posedge clk) begin
        if (rst) begin
            prefer_wr <= 1'b0;
            lock_q    <= 1'b0;
            lock_wr_q <= 1'b0;
        end else begin
            // After a read goes out the write side gets the next tie, and the
            // other way round
            if (accepted) begin
                prefer_wr <= grant_rd;
            end
            // Hold the current choice while the port is stalled, so the
            // merged strobe does not move to the other channel
            lock_q    <= (grant_rd || grant_wr) && mem_waitrequest;
            lock_wr_q <= grant_wr;
        end
    end

    // Responses carry their own valid bits and go straight to their channels
    assign rd_readdatavalid      = mem_rsp.readdatavalid;
    assign rd_readdata           = mem_rsp.readdata;
    assign wr_writeresponsevalid = mem_rsp.writeresponsevalid;

endmodule

// ==== hw/avalon_mem_reg_stages.sv ====
module avalon_mem_reg_stages #(
    parameter int NUM_STAGES = 1
) (
    input  logic                   clk,
    input  logic                   rst,

    // Side facing the converter
    input  host_mem_pkg::mem_req_t up_req,
    output logic                   up_waitrequest,
    output host_mem_pkg::mem_rsp_t up_rsp,

    // Side facing the memory endpoint
    output host_mem_pkg::mem_req_t down_req,
    input  logic                   down_waitrequest,
    input  host_mem_pkg::mem_rsp_t down_rsp
);

    // Links between stages
    // Index 0 is the upstream end and index NUM_STAGES the downstream end
    host_mem_pkg::mem_req_t req_c  [NUM_STAGES+1];
    logic                   wait_c [NUM_STAGES+1];
    host_mem_pkg::mem_rsp_t rsp_c  [NUM_STAGES+1];

    assign req_c[0]           = up_req;
    assign up_waitrequest     = wait_c[0];
    assign up_rsp             = rsp_c[0];
    assign down_req           = req_c[NUM_STAGES];
    assign wait_c[NUM_STAGES] = down_waitrequest;
    assign rsp_c[NUM_STAGES]  = down_rsp;

    // With no stages the links above connect both ends directly
    for (genvar i = 0; i < NUM_STAGES; i++) begin : g_stage
        host_mem_pkg::mem_req_t main_q;
        host_mem_pkg::mem_req_t skid_q;
        logic                   skid_full;
        host_mem_pkg::mem_rsp_t rsp_q;
        logic                   in_valid;
        logic                   in_take;
        logic                   main_move;

        // A request is present when either strobe is set
        assign in_valid = req_c[i].read || req_c[i].write;

        // The stall seen upstream is a register, so no path crosses the stage
        assign in_take = in_valid && !skid_full;

        // The main register may load when it is empty or being taken
        assign main_move = !(main_q.read || main_q.write) || !wait_c[i+1];

        always_ff @(posedge clk) begin
            if (rst) begin
                main_q.read  <= 1'b0;
                main_q.write <= 1'b0;
                skid_q.read  <= 1'b0;
                skid_q.write <= 1'b0;
                skid_full    <= 1'b0;
            end else if (main_move) begin
                // Drain the skid entry first, it is older than the input
                if (skid_full) begin
                    main_q <= skid_q;
                end else if (in_take) begin
                    main_q <= req_c[i];
                end else begin
                    main_q.read  <= 1'b0;
                    main_q.write <= 1'b0;
                end
                skid_full <= 1'b0;
            end else if (in_take) begin
                // Main is stalled, so park the request that was in flight
                skid_q    <= req_c[i];
                skid_full <= 1'b1;
            end
        end

        // Responses are never stalled and only need one register
        always_ff @(posedge clk) begin
            if (rst) begin
                rsp_q.readdatavalid      <= 1'b0;
                rsp_q.writeresponsevalid <= 1'b0;
            end else begin
                rsp_q <= rsp_c[i+1];
            end
        end

        assign req_c[i+1] = main_q;
        assign wait_c[i]  = skid_full;
        assign rsp_c[i]   = rsp_q;
    end

endmodule

// ==== hw/host_mem_endpoint.sv ====
`include "host_mem_settings.svh"

module host_mem_endpoint (
    input  logic                   clk,
    input  logic                   rst,
    input  host_mem_pkg::mem_req_t req,
    output logic                   waitrequest,
    output host_mem_pkg::mem_rsp_t rsp
);

    localparam int RD_LAT = `HOST_MEM_RD_LATENCY;
    localparam int WR_LAT = `HOST_MEM_WR_LATENCY;
    localparam int PERIOD = `HOST_MEM_WAIT_PERIOD;

    // A period of one still needs a counter bit
    localparam int CNT_W  = (PERIOD > 1) ? $clog2(PERIOD) : 1;

    // Word storage with no reset
    host_mem_pkg::data_t mem [`HOST_MEM_DEPTH];

    // Back-pressure counter
    logic [CNT_W-1:0] wait_cnt;

    // Read pipeline, valid bits and the data that travels with them
    logic                rd_valid_q [RD_LAT];
    host_mem_pkg::data_t rd_data_q  [RD_LAT];

    // Write response pipeline carries only valid bits
    logic [WR_LAT-1:0] wr_valid_q;

    logic accept_rd;
    logic accept_wr;

    // Free-running count, wrapping at the end of each period
    always_ff @(posedge clk) begin
        if (rst || (wait_cnt == CNT_W'(PERIOD - 1))) begin
            wait_cnt <= '0;
        end else begin
            wait_cnt <= wait_cnt + 1'b1;
        end
    end

    // Stall in the last cycle of every period
    assign waitrequest = (wait_cnt == CNT_W'(PERIOD - 1));

    assign accept_rd = req.read && !waitrequest;
    assign accept_wr = req.write && !waitrequest;

    // Writes land at once, one byte lane at a time
    always_ff @(posedge clk) begin
        if (accept_wr) begin
            for (int b = 0; b < `HOST_MEM_BE_W; b++) begin
                if (req.byteenable[b]) begin
                    mem[req.address][b*8 +: 8] <= req.writedata[b*8 +: 8];
                end
            end
        end
    end

    // The addressed word is sampled every cycle and shifted along
    // Only the words that travel with a valid bit are ever used
    always_ff @(posedge clk) begin
        rd_data_q[0] <= mem[req.address];
        for (int s = 1; s < RD_LAT; s++) begin
            rd_data_q[s] <= rd_data_q[s-1];
        end
    end

    // Valid bits follow the data, so the last stage fires at n plus RD_LAT
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < RD_LAT; s++) begin
                rd_valid_q[s] <= 1'b0;
            end
        end else begin
            rd_valid_q[0] <= accept_rd;
            for (int s = 1; s < RD_LAT; s++) begin
                rd_valid_q[s] <= rd_valid_q[s-1];
            end
        end
    end

    // Write responses use a plain shift register of the same kind
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_valid_q <= '0;
        end else begin
            wr_valid_q <= (wr_valid_q << 1) | WR_LAT'(accept_wr);
        end
    end

    // Last stage of each pipeline drives the response
    always_comb begin
        rsp.readdatavalid      = rd_valid_q[RD_LAT-1];
        rsp.readdata           = rd_data_q[RD_LAT-1];
        rsp.writeresponsevalid = wr_valid_q[WR_LAT-1];
    end

endmodule

// ==== hw/host_mem_rdwr_top.sv ====
`include "host_mem_settings.svh"

module host_mem_rdwr_top (
    input  logic                  clk,
    input  logic                  rst,

    // Read channel
    input  logic                  rd_read,
    input  host_mem_pkg::rd_req_t rd_req,
    output logic                  rd_waitrequest,
    output logic                  rd_readdatavalid,
    output host_mem_pkg::data_t   rd_readdata,

    // Write channel
    input  logic                  wr_write,
    input  host_mem_pkg::wr_req_t wr_req,
    output logic                  wr_waitrequest,
    output logic                  wr_writeresponsevalid
);

    // Between the converter and the stage chain
    host_mem_pkg::mem_req_t conv_req;
    logic                   conv_waitrequest;
    host_mem_pkg::mem_rsp_t conv_rsp;

    // Between the stage chain and the endpoint
    host_mem_pkg::mem_req_t ep_req;
    logic                   ep_waitrequest;
    host_mem_pkg::mem_rsp_t ep_rsp;

    // Merge the split channels onto one Avalon port
    avalon_rdwr_to_mem u_rdwr (
        .clk                   (clk),
        .rst                   (rst),
        .rd_read               (rd_read),
        .rd_req                (rd_req),
        .rd_waitrequest        (rd_waitrequest),
        .rd_readdatavalid      (rd_readdatavalid),
        .rd_readdata           (rd_readdata),
        .wr_write              (wr_write),
        .wr_req                (wr_req),
        .wr_waitrequest        (wr_waitrequest),
        .wr_writeresponsevalid (wr_writeresponsevalid),
        .mem_req               (conv_req),
        .mem_waitrequest       (conv_waitrequest),
        .mem_rsp               (conv_rsp)
    );

    // Timing registers, each adding a cycle in both directions
    avalon_mem_reg_stages #(
        .NUM_STAGES (`HOST_MEM_TIMING_STAGES)
    ) u_stages (
        .clk              (clk),
        .rst              (rst),
        .up_req           (conv_req),
        .up_waitrequest   (conv_waitrequest),
        .up_rsp           (conv_rsp),
        .down_req         (ep_req),
        .down_waitrequest (ep_waitrequest),
        .down_rsp         (ep_rsp)
    );

    // Host memory model standing in for the FIU
    host_mem_endpoint u_mem (
        .clk         (clk),
        .rst         (rst),
        .req         (ep_req),
        .waitrequest (ep_waitrequest),
        .rsp         (ep_rsp)
    );

endmodule

// ==== verif/host_mem_rdwr_tb.sv ====
`include "host_mem_settings.svh"

module host_mem_rdwr_tb;

    localparam int PERIOD    = 40;
    localparam int DRIVE_DLY = 2;

    // About 110 operations in all, each bounded by stalls, arbitration and the pipelines
    localparam int NUM_OPS        = 110;
    localparam int WORST_LAT      = `HOST_MEM_RD_LATENCY + 2 * `HOST_MEM_TIMING_STAGES + 12;
    localparam int TIMEOUT_CYCLES = 8 + 200 + NUM_OPS * WORST_LAT * 2;

    logic                  clk;
    logic                  rst;
    logic                  rd_read;
    host_mem_pkg::rd_req_t rd_req;
    logic                  rd_waitrequest;
    logic                  rd_readdatavalid;
    host_mem_pkg::data_t   rd_readdata;
    logic                  wr_write;
    host_mem_pkg::wr_req_t wr_req;
    logic                  wr_waitrequest;
    logic                  wr_writeresponsevalid;

    // Shadow copy of host memory, plus the read data still owed in request order
    host_mem_pkg::data_t shadow [`HOST_MEM_DEPTH];
    host_mem_pkg::data_t rd_exp_q [$];

    integer seed;
    int     errors = 0;
    int     rd_acc = 0;
    int     wr_acc = 0;
    int     rd_rsp = 0;
    int     wr_rsp = 0;
    int     cycles;

    host_mem_rdwr_top u_host_mem_rdwr_top (
        .clk                   (clk),
        .rst                   (rst),
        .rd_read               (rd_read),
        .rd_req                (rd_req),
        .rd_waitrequest        (rd_waitrequest),
        .rd_readdatavalid      (rd_readdatavalid),
        .rd_readdata           (rd_readdata),
        .wr_write              (wr_write),
        .wr_req                (wr_req),
        .wr_waitrequest        (wr_waitrequest),
        .wr_writeresponsevalid (wr_writeresponsevalid)
    );

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // Hard stop if the tests stall somewhere
    initial begin
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("STATUS: FAIL");
        $finish;
    end

    // Responses are sampled mid-cycle where they are stable
    // Reads come back in order, so the oldest expected word is the one to match
    always @(negedge clk) begin
        host_mem_pkg::data_t exp_data;
        if (!rst && rd_readdatavalid) begin
            rd_rsp++;
            if (rd_exp_q.size() == 0) begin
                errors++;
                $display("Read response at time %0t arrived with no read outstanding", $time);
            end else begin
                exp_data = rd_exp_q.pop_front();
                if (rd_readdata !== exp_data) begin
                    errors++;
                    $display("Fail at %0t: read data %h, expected %h",
                             $time, rd_readdata, exp_data);
                end
            end
        end
        if (!rst && wr_writeresponsevalid) begin
            wr_rsp++;
            if (wr_rsp > wr_acc) begin
                errors++;
                $display("Write response at time %0t arrived with no write outstanding", $time);
            end
        end
    end

    // Byte lanes with their enable set take the new data, the rest keep the old word
    function automatic host_mem_pkg::data_t merge_bytes(input host_mem_pkg::data_t old_word,
                                                        input host_mem_pkg::data_t new_word,
                                                        input host_mem_pkg::be_t   be);
        host_mem_pkg::data_t merged;
        merged = old_word;
        for (int b = 0; b < `HOST_MEM_BE_W; b++) begin
            if (be[b]) begin
                merged[b*8 +: 8] = new_word[b*8 +: 8];
            end
        end
        return merged;
    endfunction

    function automatic host_mem_pkg::data_t random_word();
        return {$random(seed), $random(seed)};
    endfunction

    function automatic host_mem_pkg::addr_t upper_half_addr();
        host_mem_pkg::addr_t addr;
        addr = host_mem_pkg::addr_t'($random(seed));
        addr[`HOST_MEM_ADDR_W-1] = 1'b1;
        return addr;
    endfunction

    // Present a write and hold it until a cycle without waitrequest takes it
    // The strobe stays high on return so calls can run back to back
    task automatic issue_write(input host_mem_pkg::addr_t addr,
                               input host_mem_pkg::data_t data,
                               input host_mem_pkg::be_t   be);
        logic taken;
        wr_write          = 1'b1;
        wr_req.address    = addr;
        wr_req.writedata  = data;
        wr_req.byteenable = be;
        taken = 1'b0;
        while (!taken) begin
            @(negedge clk);
            taken = !wr_waitrequest;
            @(posedge clk);
            #DRIVE_DLY;
        end
        shadow[addr] = merge_bytes(shadow[addr], data, be);
        wr_acc++;
    endtask

    // Same handshake on the read side, recording the word the read must return
    task automatic issue_read(input host_mem_pkg::addr_t addr);
        logic taken;
        rd_read        = 1'b1;
        rd_req.address = addr;
        taken = 1'b0;
        while (!taken) begin
            @(negedge clk);
            taken = !rd_waitrequest;
            @(posedge clk);
            #DRIVE_DLY;
        end
        rd_exp_q.push_back(shadow[addr]);
        rd_acc++;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #DRIVE_DLY;
        end
    endtask

    // Wait until every accepted request has had its response
    task automatic wait_done();
        while (rd_rsp != rd_acc || wr_rsp != wr_acc) begin
            @(posedge clk);
            #DRIVE_DLY;
        end
    endtask

    task automatic expect_count(input string what, input int got, input int exp);
        if (got != exp) begin
            errors++;
            $display("Fail at %0t: %s count %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    // Both valids must be a clean zero in every idle cycle, an unknown counts as wrong
    task automatic check_idle_after_reset();
        repeat (20) begin
            @(negedge clk);
            if (rd_readdatavalid !== 1'b0 || wr_writeresponsevalid !== 1'b0) begin
                errors++;
                $display("Fail at %0t: idle valids rd=%b wr=%b, expected 0 and 0",
                         $time, rd_readdatavalid, wr_writeresponsevalid);
            end
        end
        @(posedge clk);
        #DRIVE_DLY;
    endtask

    task automatic write_read_roundtrip();
        host_mem_pkg::addr_t addr;
        int rd_base;
        int wr_base;
        addr    = host_mem_pkg::addr_t'($random(seed));
        rd_base = rd_rsp;
        wr_base = wr_rsp;
        issue_write(addr, random_word(), '1);
        wr_write = 1'b0;
        wait_done();
        issue_read(addr);
        rd_read = 1'b0;
        wait_done();
        // Extra responses would show up during this quiet gap
        idle_cycles(10);
        expect_count("roundtrip write response", wr_rsp - wr_base, 1);
        expect_count("roundtrip read response", rd_rsp - rd_base, 1);
    endtask

    task automatic partial_write_merge();
        host_mem_pkg::addr_t addr;
        host_mem_pkg::be_t   masks [4];
        int rd_base;
        masks = '{8'h0f, 8'hf0, 8'h81, 8'h3c};
        addr  = host_mem_pkg::addr_t'($random(seed));
        // A full write first, so every byte of the word is known
        issue_write(addr, random_word(), '1);
        wr_write = 1'b0;
        wait_done();
        for (int i = 0; i < 4; i++) begin
            issue_write(addr, random_word(), masks[i]);
            wr_write = 1'b0;
            wait_done();
        end
        rd_base = rd_rsp;
        issue_read(addr);
        rd_read = 1'b0;
        wait_done();
        expect_count("merge read response", rd_rsp - rd_base, 1);
    endtask

    task automatic back_to_back_reads();
        int rd_base;
        for (int i = 0; i < 32; i++) begin
            issue_write(host_mem_pkg::addr_t'(i), random_word(), '1);
        end
        wr_write = 1'b0;
        wait_done();
        rd_base = rd_rsp;
        // Stride 7 visits sixteen distinct words of the preloaded block
        for (int i = 0; i < 16; i++) begin
            issue_read(host_mem_pkg::addr_t'((i * 7) % 32));
        end
        rd_read = 1'b0;
        wait_done();
        expect_count("back-to-back read response", rd_rsp - rd_base, 16);
    endtask

    // Writes go to the upper half and reads to the preloaded lower block, so the
    // two streams never touch the same word
    task automatic concurrent_streams();
        host_mem_pkg::addr_t wr_addr [24];
        host_mem_pkg::data_t wr_data [24];
        host_mem_pkg::be_t   wr_be   [24];
        host_mem_pkg::addr_t rd_addr [24];
        int rd_base;
        int wr_base;
        // All random values are drawn here, before the two streams start
        for (int i = 0; i < 24; i++) begin
            wr_addr[i] = upper_half_addr();
            wr_data[i] = random_word();
            wr_be[i]   = host_mem_pkg::be_t'($random(seed));
            rd_addr[i] = host_mem_pkg::addr_t'($unsigned($random(seed)) % 32);
        end
        rd_base = rd_rsp;
        wr_base = wr_rsp;
        fork
            begin
                for (int i = 0; i < 24; i++) begin
                    issue_write(wr_addr[i], wr_data[i], wr_be[i]);
                end
                wr_write = 1'b0;
            end
            begin
                for (int i = 0; i < 24; i++) begin
                    issue_read(rd_addr[i]);
                end
                rd_read = 1'b0;
            end
        join
        wait_done();
        idle_cycles(10);
        expect_count("stream write response", wr_rsp - wr_base, 24);
        expect_count("stream read response", rd_rsp - rd_base, 24);
    endtask

    initial begin
        seed     = 32'hce92;
        rst      = 1'b1;
        rd_read  = 1'b0;
        rd_req   = '0;
        wr_write = 1'b0;
        wr_req   = '0;
        repeat (8) @(posedge clk);
        #DRIVE_DLY;
        rst = 1'b0;

        check_idle_after_reset();
        write_read_roundtrip();
        partial_write_merge();
        back_to_back_reads();
        concurrent_streams();

        idle_cycles(10);
        $display("Done: errors=%0d reads=%0d writes=%0d", errors, rd_rsp, wr_rsp);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// ==== sources.f ====
+incdir+hw
hw/host_mem_pkg.sv
hw/avalon_rdwr_to_mem.sv
hw/avalon_mem_reg_stages.sv
hw/host_mem_endpoint.sv
hw/host_mem_rdwr_top.sv
verif/host_mem_rdwr_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= host_mem_rdwr_tb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_MSG  := STATUS: PASS

SRCS := $(wildcard hw/*.sv hw/*.svh verif/*.sv)
SIM  := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

$(SIM): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

test: $(SIM)
	./$(SIM) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
